// ==== rtl/sd_rx_pkg.sv ====
package sd_rx_pkg;

  // ##################################################
  // block geometry
  // ##################################################

  localparam int BLOCK_BYTES = 512;
  localparam int FIFO_DEPTH  = 16;
  localparam int CRC_BITS    = 16;

  // ##################################################
  // state and result encodings
  // ##################################################

  // ERROR is only entered from an illegal encoding
  typedef enum logic [1:0] {
    OUTPUT,
    START,
    CALCULATE,
    ERROR
  } crc_state_e;

  typedef enum logic [1:0] {
    IDLE,
    DATA,
    CRC,
    STOP
  } rx_state_e;

  typedef enum logic [1:0] {
    BLK_OK,
    BLK_CRC_ERR,
    BLK_END_ERR
  } blk_status_e;

endpackage

// ==== rtl/rx_byte_if.sv ====
`timescale 1ns/1ps

interface rx_byte_if;

  // one-cycle write strobe from the framer
  logic       push;
  logic [7:0] data;
  // set together with the final data byte of a block
  logic       last;
  // level from the FIFO that drops any push made while it is high
  logic       full;

  modport push_mp (
    output push,
    output data,
    output last,
    input  full
  );

  modport store_mp (
    input  push,
    input  data,
    input  last,
    output full
  );

endinterface

// ==== rtl/crc16_read.sv ====
`timescale 1ns/1ps

module crc16_read (
  input  logic        sd_clk_i,
  input  logic        rst_i,
  input  logic        start_i,
  input  logic        end_output_i,
  input  logic        dat_ser_i,
  output logic [15:0] crc16_o
);

  sd_rx_pkg::crc_state_e crc_state_q, crc_state_d;

  // register split at the two inner taps of x^16+x^12+x^5+1
  logic [4:0] lower_5_d, lower_5_q;
  logic [6:0] middle_7_d, middle_7_q;
  logic [3:0] upper_4_d, upper_4_q;
  logic       clear;
  logic       feedback;

  // ##################################################
  // state machine
  // ##################################################

  always_comb begin
    crc_state_d = crc_state_q;
    unique case (crc_state_q)
      sd_rx_pkg::OUTPUT:    crc_state_d = start_i ? sd_rx_pkg::START : sd_rx_pkg::OUTPUT;
      sd_rx_pkg::START:     crc_state_d = sd_rx_pkg::CALCULATE;
      sd_rx_pkg::CALCULATE: crc_state_d = end_output_i ? sd_rx_pkg::OUTPUT : sd_rx_pkg::CALCULATE;
      default:              crc_state_d = sd_rx_pkg::ERROR;
    endcase
  end

  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      crc_state_q <= sd_rx_pkg::OUTPUT;
    end else begin
      crc_state_q <= crc_state_d;
    end
  end

  // ##################################################
  // shift register
  // ##################################################

  always_comb begin
    lower_5_d  = lower_5_q;
    middle_7_d = middle_7_q;
    upper_4_d  = upper_4_q;
    clear      = 1'b0;
    feedback   = dat_ser_i ^ upper_4_q[3];
    // held at zero while calculating so downstream compare logic stays quiet
    crc16_o    = 16'h0000;

    unique case (crc_state_q)
      sd_rx_pkg::OUTPUT: begin
        crc16_o = {upper_4_q, middle_7_q, lower_5_q};
      end
      sd_rx_pkg::START: begin
        clear = 1'b1;
      end
      sd_rx_pkg::CALCULATE: begin
        lower_5_d  = {lower_5_q[3:0], feedback};
        middle_7_d = {middle_7_q[5:0], lower_5_q[4] ^ feedback};
        upper_4_d  = {upper_4_q[2:0], middle_7_q[6] ^ feedback};
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge sd_clk_i) begin
    if (rst_i || clear) begin
      lower_5_q  <= '0;
      middle_7_q <= '0;
      upper_4_q  <= '0;
    end else begin
      lower_5_q  <= lower_5_d;
      middle_7_q <= middle_7_d;
      upper_4_q  <= upper_4_d;
    end
  end

  a_no_error_state: assert property (@(posedge sd_clk_i) disable iff (rst_i)
    crc_state_q != sd_rx_pkg::ERROR);

  // the framer only starts a block while it is idle
  a_no_start_in_calc: assert property (@(posedge sd_clk_i) disable iff (rst_i)
    !(start_i && crc_state_q == sd_rx_pkg::CALCULATE));

endmodule

// ==== rtl/sd_dat_rx.sv ====
`timescale 1ns/1ps

module sd_dat_rx (
  input  logic                   sd_clk_i,
  input  logic                   rst_i,
  input  logic                   dat_ser_i,
  rx_byte_if.push_mp             byte_if,
  output logic                   blk_done_o,
  output sd_rx_pkg::blk_status_e blk_status_o,
  output logic                   overrun_o
);

  sd_rx_pkg::rx_state_e   state_q;
  sd_rx_pkg::blk_status_e status_q;

  logic                                      dat_q;
  logic                                      start;
  logic                                      start_q;
  logic                                      end_output;
  logic                                      last_byte;
  logic [2:0]                                bit_cnt_q;
  logic [$clog2(sd_rx_pkg::BLOCK_BYTES)-1:0] byte_cnt_q;
  logic [$clog2(sd_rx_pkg::CRC_BITS)-1:0]    crc_cnt_q;
  logic [7:0]                                shift_q;
  logic [7:0]                                data_q;
  logic                                      last_q;
  logic                                      push_q;
  logic [sd_rx_pkg::CRC_BITS-1:0]            crc_rx_q;
  logic [15:0]                               crc_calc;
  logic                                      fin_q;
  logic                                      done_q;
  logic                                      overrun_q;

  // start is taken from the raw line so the CRC engine has cleared by the first data bit
  assign start      = (state_q == sd_rx_pkg::IDLE) && !start_q && !dat_ser_i;
  assign last_byte  = (byte_cnt_q == sd_rx_pkg::BLOCK_BYTES - 1);
  assign end_output = (state_q == sd_rx_pkg::DATA) && (bit_cnt_q == 3'd7) && last_byte;

  crc16_read i_crc (
    .sd_clk_i     (sd_clk_i),
    .rst_i        (rst_i),
    .start_i      (start),
    .end_output_i (end_output),
    .dat_ser_i    (dat_q),
    .crc16_o      (crc_calc)
  );

  // ##################################################
  // framing control
  // ##################################################

  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      dat_q      <= 1'b1;
      state_q    <= sd_rx_pkg::IDLE;
      start_q    <= 1'b0;
      bit_cnt_q  <= '0;
      byte_cnt_q <= '0;
      crc_cnt_q  <= '0;
      push_q     <= 1'b0;
      fin_q      <= 1'b0;
      done_q     <= 1'b0;
      status_q   <= sd_rx_pkg::BLK_OK;
      overrun_q  <= 1'b0;
    end else begin
      dat_q   <= dat_ser_i;
      start_q <= start;
      push_q  <= 1'b0;
      fin_q   <= 1'b0;
      done_q  <= fin_q;
      // sticky until reset
      if (byte_if.push && byte_if.full) begin
        overrun_q <= 1'b1;
      end
      unique case (state_q)
        sd_rx_pkg::IDLE: begin
          if (start_q) begin
            state_q    <= sd_rx_pkg::DATA;
            bit_cnt_q  <= '0;
            byte_cnt_q <= '0;
          end
        end
        sd_rx_pkg::DATA: begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
          if (bit_cnt_q == 3'd7) begin
            push_q     <= 1'b1;
            byte_cnt_q <= byte_cnt_q + 1'b1;
            if (last_byte) begin
              state_q   <= sd_rx_pkg::CRC;
              crc_cnt_q <= '0;
            end
          end
        end
        sd_rx_pkg::CRC: begin
          crc_cnt_q <= crc_cnt_q + 1'b1;
          if (crc_cnt_q == sd_rx_pkg::CRC_BITS - 1) begin
            state_q <= sd_rx_pkg::STOP;
          end
        end
        sd_rx_pkg::STOP: begin
          // dat_q holds the end bit here
          if (crc_rx_q != crc_calc) begin
            status_q <= sd_rx_pkg::BLK_CRC_ERR;
          end else if (!dat_q) begin
            status_q <= sd_rx_pkg::BLK_END_ERR;
          end else begin
            status_q <= sd_rx_pkg::BLK_OK;
          end
          fin_q   <= 1'b1;
          state_q <= sd_rx_pkg::IDLE;
        end
        default: state_q <= sd_rx_pkg::IDLE;
      endcase
    end
  end

  // ##################################################
  // data and received CRC
  // ##################################################

  always_ff @(posedge sd_clk_i) begin
    if (state_q == sd_rx_pkg::DATA) begin
      shift_q <= {shift_q[6:0], dat_q};
      if (bit_cnt_q == 3'd7) begin
        data_q <= {shift_q[6:0], dat_q};
        last_q <= last_byte;
      end
    end
    if (state_q == sd_rx_pkg::CRC) begin
      crc_rx_q <= {crc_rx_q[sd_rx_pkg::CRC_BITS-2:0], dat_q};
    end
  end

  assign byte_if.push = push_q;
  assign byte_if.data = data_q;
  assign byte_if.last = last_q;
  assign blk_done_o   = done_q;
  assign blk_status_o = status_q;
  assign overrun_o    = overrun_q;

  a_push_after_data: assert property (@(posedge sd_clk_i) disable iff (rst_i)
    byte_if.push |-> $past(state_q) == sd_rx_pkg::DATA);

endmodule

// ==== rtl/rx_byte_fifo.sv ====
`timescale 1ns/1ps

module rx_byte_fifo (
  input  logic        sd_clk_i,
  input  logic        rst_i,
  rx_byte_if.store_mp byte_if,
  input  logic        pop_i,
  output logic [7:0]  rd_data_o,
  output logic        rd_last_o,
  output logic        empty_o
);

  // each entry is {last, data}
  logic [8:0] mem_q [sd_rx_pkg::FIFO_DEPTH];

  logic [$clog2(sd_rx_pkg::FIFO_DEPTH)-1:0]   wr_ptr_q;
  logic [$clog2(sd_rx_pkg::FIFO_DEPTH)-1:0]   rd_ptr_q;
  logic [$clog2(sd_rx_pkg::FIFO_DEPTH+1)-1:0] count_q;
  logic                                       wr_en;
  logic                                       rd_en;

  assign byte_if.full = (count_q == sd_rx_pkg::FIFO_DEPTH);
  assign empty_o      = (count_q == '0);
  assign wr_en        = byte_if.push && !byte_if.full;
  assign rd_en        = pop_i && !empty_o;

  // head entry is shown without a register stage
  assign {rd_last_o, rd_data_o} = mem_q[rd_ptr_q];

  always_ff @(posedge sd_clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= {byte_if.last, byte_if.data};
    end
  end

  // pointers wrap naturally as the depth is a power of two
  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_pop_empty: assert property (@(posedge sd_clk_i) disable iff (rst_i)
    pop_i |-> !empty_o);

  a_count_bound: assert property (@(posedge sd_clk_i) disable iff (rst_i)
    count_q <= sd_rx_pkg::FIFO_DEPTH);

endmodule

// ==== rtl/word_packer.sv ====
`timescale 1ns/1ps

module word_packer (
  input  logic        sd_clk_i,
  input  logic        rst_i,
  input  logic [7:0]  rd_data_i,
  input  logic        rd_last_i,
  input  logic        empty_i,
  output logic        pop_o,
  output logic [31:0] word_o,
  output logic        word_valid_o,
  output logic        word_last_o,
  input  logic        word_ready_i
);

  logic [1:0]  lane_q;
  logic [31:0] word_q;
  logic        valid_q;
  logic        last_q;
  logic        accept;

  // popping stops while a finished word waits for the host
  assign pop_o  = !valid_q && !empty_i;
  assign accept = valid_q && word_ready_i;

  always_ff @(posedge sd_clk_i) begin
    if (rst_i) begin
      lane_q  <= '0;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      if (accept) begin
        valid_q <= 1'b0;
      end
      if (pop_o) begin
        lane_q <= lane_q + 2'd1;
        // lane 0 starts a new word so the flag is not carried over
        last_q <= (lane_q == 2'd0) ? rd_last_i : (last_q | rd_last_i);
        if (lane_q == 2'd3) begin
          valid_q <= 1'b1;
        end
      end
    end
  end

  // first byte of a word lands in the low lane
  always_ff @(posedge sd_clk_i) begin
    if (pop_o) begin
      word_q[{lane_q, 3'b000} +: 8] <= rd_data_i;
    end
  end

  assign word_o       = word_q;
  assign word_valid_o = valid_q;
  assign word_last_o  = last_q;

  a_hold_word: assert property (@(posedge sd_clk_i) disable iff (rst_i)
    word_valid_o && !word_ready_i |=> word_valid_o && $stable(word_o));

endmodule

// ==== rtl/sd_rx_top.sv ====
`timescale 1ns/1ps

module sd_rx_top (
  input  logic        sd_clk_i,
  input  logic        rst_i,
  input  logic        dat_ser_i,
  input  logic        word_ready_i,
  output logic [31:0] word_o,
  output logic        word_valid_o,
  output logic        word_last_o,
  output logic        blk_done_o,
  output logic [1:0]  blk_status_o,
  output logic        overrun_o
);

  logic [7:0] fifo_data;
  logic       fifo_last;
  logic       fifo_empty;
  logic       fifo_pop;

  rx_byte_if i_byte_if ();

  sd_dat_rx i_dat_rx (
    .sd_clk_i     (sd_clk_i),
    .rst_i        (rst_i),
    .dat_ser_i    (dat_ser_i),
    .byte_if      (i_byte_if.push_mp),
    .blk_done_o   (blk_done_o),
    .blk_status_o (blk_status_o),
    .overrun_o    (overrun_o)
  );

  rx_byte_fifo i_fifo (
    .sd_clk_i  (sd_clk_i),
    .rst_i     (rst_i),
    .byte_if   (i_byte_if.store_mp),
    .pop_i     (fifo_pop),
    .rd_data_o (fifo_data),
    .rd_last_o (fifo_last),
    .empty_o   (fifo_empty)
  );

  word_packer i_packer (
    .sd_clk_i     (sd_clk_i),
    .rst_i        (rst_i),
    .rd_data_i    (fifo_data),
    .rd_last_i    (fifo_last),
    .empty_i      (fifo_empty),
    .pop_o        (fifo_pop),
    .word_o       (word_o),
    .word_valid_o (word_valid_o),
    .word_last_o  (word_last_o),
    .word_ready_i (word_ready_i)
  );

endmodule

// ==== tests/tb_sd_rx.sv ====
`timescale 1ns/1ps

module tb_sd_rx;

  localparam int NUM_BLOCKS   = 7;
  localparam int IDLE_BITS    = 8;
  localparam int MAX_CYCLES   = NUM_BLOCKS * (sd_rx_pkg::BLOCK_BYTES * 8 + 40) + 200;
  localparam int READY_ALWAYS = 0;
  localparam int READY_RANDOM = 1;
  localparam int READY_NEVER  = 2;

  logic        sd_clk_i;
  logic        rst_i;
  logic        dat_ser_i;
  logic        word_ready_i;
  logic [31:0] word_o;
  logic        word_valid_o;
  logic        word_last_o;
  logic        blk_done_o;
  logic [1:0]  blk_status_o;
  logic        overrun_o;

  integer seed;
  integer ready_rnd;
  int     cycle_cnt;
  int     ready_mode;
  int     blocks_seen;
  bit     compare_en;

  logic [7:0]             blk_data [sd_rx_pkg::BLOCK_BYTES];
  logic [31:0]            exp_words [$];
  logic                   exp_lasts [$];
  sd_rx_pkg::blk_status_e exp_status [$];

  sd_rx_top i_dut (
    .sd_clk_i     (sd_clk_i),
    .rst_i        (rst_i),
    .dat_ser_i    (dat_ser_i),
    .word_ready_i (word_ready_i),
    .word_o       (word_o),
    .word_valid_o (word_valid_o),
    .word_last_o  (word_last_o),
    .blk_done_o   (blk_done_o),
    .blk_status_o (blk_status_o),
    .overrun_o    (overrun_o)
  );

  always #4 sd_clk_i = ~sd_clk_i;

  // ##################################################
  // failure reporting and checks
  // ##################################################

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped after the first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %08h actual %08h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_status(input sd_rx_pkg::blk_status_e exp,
                              input sd_rx_pkg::blk_status_e act);
    if (act !== exp) begin
      $display("ERR t=%0t blk_status_o expected %s (%0d) actual %s (%0d)",
               $time, exp.name(), exp, act.name(), act);
      abort_run();
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // ##################################################
  // reference model
  // ##################################################

  // bitwise CRC16-CCITT over the first num_bytes of blk_data, MSB first, zero start
  function automatic logic [15:0] crc16_ref(input int num_bytes);
    logic [15:0] crc;
    logic        fb;
    int          i;
    int          j;
    crc = 16'h0000;
    for (i = 0; i < num_bytes; i++) begin
      for (j = 7; j >= 0; j--) begin
        fb  = blk_data[i][j] ^ crc[15];
        crc = {crc[14:0], 1'b0};
        if (fb) begin
          crc = crc ^ 16'h1021;
        end
      end
    end
    return crc;
  endfunction

  task automatic fill_random();
    int i;
    for (i = 0; i < sd_rx_pkg::BLOCK_BYTES; i++) begin
      blk_data[i] = $random(seed);
    end
  endtask

  // the first byte of each group of four is the least significant
  task automatic queue_expected(input sd_rx_pkg::blk_status_e status);
    int i;
    for (i = 0; i < sd_rx_pkg::BLOCK_BYTES / 4; i++) begin
      exp_words.push_back({blk_data[4*i+3], blk_data[4*i+2], blk_data[4*i+1], blk_data[4*i]});
      exp_lasts.push_back(i == sd_rx_pkg::BLOCK_BYTES / 4 - 1);
    end
    exp_status.push_back(status);
  endtask

  // ##################################################
  // stimulus
  // ##################################################

  task automatic drive_bit(input logic b);
    @(negedge sd_clk_i);
    dat_ser_i = b;
  endtask

  // flip_bit below zero leaves the CRC intact
  task automatic send_block(input int flip_bit, input logic end_bit);
    logic [15:0] crc;
    int          i;
    int          j;
    crc = crc16_ref(sd_rx_pkg::BLOCK_BYTES);
    if (flip_bit >= 0) begin
      crc[flip_bit] = ~crc[flip_bit];
    end
    drive_bit(1'b0);
    for (i = 0; i < sd_rx_pkg::BLOCK_BYTES; i++) begin
      for (j = 7; j >= 0; j--) begin
        drive_bit(blk_data[i][j]);
      end
    end
    for (j = 15; j >= 0; j--) begin
      drive_bit(crc[j]);
    end
    drive_bit(end_bit);
    repeat (IDLE_BITS) drive_bit(1'b1);
  endtask

  task automatic apply_reset();
    @(negedge sd_clk_i);
    rst_i = 1'b1;
    repeat (4) @(negedge sd_clk_i);
    rst_i = 1'b0;
  endtask

  // returns once the given number of results and all expected words are in
  task automatic wait_results(input int target);
    while (blocks_seen < target || exp_words.size() != 0) begin
      @(negedge sd_clk_i);
    end
  endtask

  always @(negedge sd_clk_i) begin
    ready_rnd = $random(seed);
    case (ready_mode)
      READY_RANDOM: word_ready_i = ready_rnd[0];
      READY_NEVER:  word_ready_i = 1'b0;
      default:      word_ready_i = 1'b1;
    endcase
  end

  // ##################################################
  // response comparison and timeout
  // ##################################################

  always @(posedge sd_clk_i) begin
    if (!rst_i && word_valid_o && word_ready_i && compare_en) begin
      if (exp_words.size() == 0) begin
        $display("a word was accepted at t=%0t when no word was expected", $time);
        abort_run();
      end else begin
        check_word("word_o", exp_words.pop_front(), word_o);
        check_flag("word_last_o", exp_lasts.pop_front(), word_last_o);
      end
    end
    if (!rst_i && blk_done_o) begin
      if (exp_status.size() == 0) begin
        $display("a block result appeared at t=%0t when none was expected", $time);
        abort_run();
      end else begin
        check_status(exp_status.pop_front(), sd_rx_pkg::blk_status_e'(blk_status_o));
        blocks_seen++;
      end
    end
  end

  always @(posedge sd_clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > MAX_CYCLES) begin
      $display("the run went past %0d cycles without finishing", MAX_CYCLES);
      abort_run();
    end
  end

  // ##################################################
  // test sequence
  // ##################################################

  initial begin
    seed         = 51962;
    sd_clk_i     = 1'b0;
    rst_i        = 1'b1;
    dat_ser_i    = 1'b1;
    word_ready_i = 1'b1;
    ready_mode   = READY_ALWAYS;
    cycle_cnt    = 0;
    blocks_seen  = 0;
    compare_en   = 1'b1;
    apply_reset();

    // good block
    fill_random();
    queue_expected(sd_rx_pkg::BLK_OK);
    send_block(-1, 1'b1);
    wait_results(1);

    // one CRC bit flipped while the data is still delivered
    fill_random();
    queue_expected(sd_rx_pkg::BLK_CRC_ERR);
    send_block($unsigned($random(seed)) % 16, 1'b1);
    wait_results(2);

    // good CRC with a low end bit
    fill_random();
    queue_expected(sd_rx_pkg::BLK_END_ERR);
    send_block(-1, 1'b0);
    wait_results(3);

    // host stalls at random but keeps up on average
    ready_mode = READY_RANDOM;
    fill_random();
    queue_expected(sd_rx_pkg::BLK_OK);
    send_block(-1, 1'b1);
    wait_results(4);
    ready_mode = READY_ALWAYS;
    check_flag("overrun_o", 1'b0, overrun_o);

    // host never ready so the FIFO overflows
    compare_en = 1'b0;
    ready_mode = READY_NEVER;
    fill_random();
    exp_status.push_back(sd_rx_pkg::BLK_OK);
    send_block(-1, 1'b1);
    wait_results(5);
    check_flag("overrun_o", 1'b1, overrun_o);
    ready_mode = READY_ALWAYS;
    repeat (40) @(negedge sd_clk_i);
    check_flag("overrun_o", 1'b1, overrun_o);
    apply_reset();
    check_flag("overrun_o", 1'b0, overrun_o);
    compare_en = 1'b1;

    // two blocks with only idle bits between them
    fill_random();
    queue_expected(sd_rx_pkg::BLK_OK);
    send_block(-1, 1'b1);
    fill_random();
    queue_expected(sd_rx_pkg::BLK_OK);
    send_block(-1, 1'b1);
    wait_results(7);

    // a few more cycles let a stray word or block result show up
    repeat (4) @(negedge sd_clk_i);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== sd_rx.f ====
rtl/sd_rx_pkg.sv
rtl/rx_byte_if.sv
rtl/crc16_read.sv
rtl/sd_dat_rx.sv
rtl/rx_byte_fifo.sv
rtl/word_packer.sv
rtl/sd_rx_top.sv
tests/tb_sd_rx.sv
